// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f sim.f --top-module exec_tb -o exec_sim
	./obj_dir/exec_sim | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== include/exec_settings.svh ====
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// width of one datapath word
// operands, pc and results all share it
`define EXEC_DATA_W 16

// opcode field width, 16 instruction kinds
`define EXEC_OP_W 4

`endif

// ==== sim.f ====
+incdir+include
verilog/exec_pkg.sv
verilog/alu.sv
verilog/ctrl_decode.sv
verilog/execute.sv
verilog/exec_top.sv
testbench/exec_tb.sv

// ==== testbench/exec_tb.sv ====
`timescale 1ns/1ns
`include "exec_settings.svh"

module exec_tb
   import exec_pkg::*;
();

   localparam int W          = `EXEC_DATA_W;
   localparam int N_DIRECTED = 6;
   localparam int N_ARITH    = 300;
   localparam int N_SHIFT    = 200;
   localparam int N_BRANCH   = 300;
   localparam int N_JUMP     = 40;
   localparam int N_STREAM   = 200;
   localparam int MAX_GAP    = 3;
   localparam int STIM_CYCLES = 16 + 4 + N_DIRECTED + N_ARITH + N_SHIFT + N_BRANCH + N_JUMP
                                + N_STREAM * (MAX_GAP + 1) + 4;
   localparam int CYCLE_LIMIT = STIM_CYCLES + 2 + 20;

   logic    clk;
   logic    arst_n;
   logic    in_valid;
   opcode_t opcode;
   word_t   oprnd_1;
   word_t   oprnd_2;
   word_t   pc_inc;
   logic    out_valid;
   logic    ofl;
   logic    pc_src;
   word_t   result;
   word_t   pc_target;

   int      cycle_cnt = 0;
   string   test_name;

   // expected items in issue order
   word_t   q_result[$];
   logic    q_ofl[$];
   logic    q_pc_src[$];
   word_t   q_target[$];
   bit      q_chk_res[$];
   int      q_due[$];
   string   q_name[$];

   exec_top dut (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .opcode    (opcode),
      .oprnd_1   (oprnd_1),
      .oprnd_2   (oprnd_2),
      .pc_inc    (pc_inc),
      .out_valid (out_valid),
      .ofl       (ofl),
      .pc_src    (pc_src),
      .result    (result),
      .pc_target (pc_target)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= CYCLE_LIMIT)
         stop_on_error($sformatf("timeout after %0d cycles", cycle_cnt));
   end

   task automatic stop_on_error(input string what);
      $display("%s", what);
      $display("Some tests failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (exp !== act)
         stop_on_error($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (exp !== act)
         stop_on_error($sformatf("CHECK FAILED %s expected %b actual %b", name, exp, act));
   endtask

   // expected outputs straight from the instruction semantics
   task automatic model(input opcode_t op, input word_t a, input word_t b, input word_t pc,
                        output word_t r, output logic o, output logic ps, output word_t tgt);
      int s;
      int exact; // unbounded signed result
      s   = int'(b[3:0]);
      r   = a + b; // control opcodes keep the add
      o   = 1'b0;
      ps  = 1'b0;
      tgt = pc + b + b;
      case (op)
         OPC_ADD: begin
            exact = int'($signed(a)) + int'($signed(b));
            o     = (exact >= (1 << (W - 1))) || (exact < -(1 << (W - 1)));
         end
         OPC_SUB: begin
            r     = b - a;
            exact = int'($signed(b)) - int'($signed(a));
            o     = (exact >= (1 << (W - 1))) || (exact < -(1 << (W - 1)));
         end
         OPC_XOR:  r = a ^ b;
         OPC_ANDN: r = a & ~b;
         OPC_ROL:  r = (a << s) | (a >> (W - s));
         OPC_SLL:  r = a << s;
         OPC_ROR:  r = (a >> s) | (a << (W - s));
         OPC_SRL:  r = a >> s;
         OPC_SLT:  r = word_t'($signed(a) < $signed(b));
         OPC_SLE:  r = word_t'($signed(a) <= $signed(b));
         OPC_BEQZ: ps = (a == '0);
         OPC_BNEZ: ps = (a != '0);
         OPC_BLTZ: ps = a[W-1];
         OPC_BGEZ: ps = !a[W-1];
         OPC_J:    ps = 1'b1;
         OPC_JR: begin
            ps  = 1'b1;
            tgt = pc + a;
         end
         default: ;
      endcase
   endtask

   task automatic check_outputs();
      string name;
      word_t e_res;
      word_t e_tgt;
      logic  e_ofl;
      logic  e_ps;
      bit    chk;
      int    due;
      if (out_valid === 1'b1) begin
         if (q_due.size() == 0)
            stop_on_error("out_valid went high with no accepted input pending");
         name  = q_name.pop_front();
         e_res = q_result.pop_front();
         e_tgt = q_target.pop_front();
         e_ofl = q_ofl.pop_front();
         e_ps  = q_pc_src.pop_front();
         chk   = q_chk_res.pop_front();
         due   = q_due.pop_front();
         if (due != cycle_cnt)
            stop_on_error($sformatf("%s item came out at cycle %0d instead of cycle %0d",
                                    name, cycle_cnt, due));
         if (chk)
            check_word({name, " result"}, e_res, result);
         check_flag({name, " ofl"}, e_ofl, ofl);
         check_flag({name, " pc_src"}, e_ps, pc_src);
         check_word({name, " pc_target"}, e_tgt, pc_target);
      end else begin
         check_flag({test_name, " idle out_valid"}, 1'b0, out_valid);
         check_flag({test_name, " idle pc_src"}, 1'b0, pc_src);
         if (q_due.size() != 0 && q_due[0] <= cycle_cnt)
            stop_on_error($sformatf("%s item due at cycle %0d never came out",
                                    q_name[0], q_due[0]));
      end
   endtask

   task automatic issue(input opcode_t op, input word_t a, input word_t b);
      word_t pc;
      word_t r;
      word_t tgt;
      logic  o;
      logic  ps;
      pc = word_t'($urandom);
      @(negedge clk);
      check_outputs();
      in_valid = 1'b1;
      opcode   = op;
      oprnd_1  = a;
      oprnd_2  = b;
      pc_inc   = pc;
      model(op, a, b, pc, r, o, ps, tgt);
      q_result.push_back(r);
      q_ofl.push_back(o);
      q_pc_src.push_back(ps);
      q_target.push_back(tgt);
      q_chk_res.push_back(op < OPC_BEQZ);
      q_due.push_back(cycle_cnt + 2); // one input edge, one output edge
      q_name.push_back(test_name);
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(negedge clk);
         check_outputs();
         in_valid = 1'b0;
         oprnd_1  = word_t'($urandom); // junk during bubbles
      end
   endtask

   function automatic word_t rand_word();
      return word_t'($urandom);
   endfunction

   function automatic word_t corner_word();
      case ($urandom_range(0, 4))
         0: return 16'h7fff;
         1: return 16'h8000;
         2: return 16'hffff;
         3: return 16'h0000;
         default: return 16'h0001;
      endcase
   endfunction

   // zero, negative or positive with equal odds
   function automatic word_t sign_class_word();
      case ($urandom_range(0, 2))
         0: return '0;
         1: return word_t'($urandom) | 16'h8000;
         default: return word_t'($urandom) & 16'h7fff;
      endcase
   endfunction

   initial begin
      word_t a;
      word_t b;
      void'($urandom(32'h37a3d5c7));
      arst_n    = 1'b0;
      in_valid  = 1'b1; // a jump strobe that reset must swallow
      opcode    = OPC_J;
      oprnd_1   = '0;
      oprnd_2   = '0;
      pc_inc    = '0;
      test_name = "reset";
      repeat (16) begin
         @(negedge clk);
         check_flag("reset out_valid", 1'b0, out_valid);
         check_flag("reset pc_src", 1'b0, pc_src);
      end
      arst_n   = 1'b1;
      in_valid = 1'b0;
      opcode   = OPC_ADD;
      idle(4);

      test_name = "arith";
      issue(OPC_ADD, 16'h7fff, 16'h0001);
      issue(OPC_ADD, 16'h8000, 16'hffff);
      issue(OPC_SUB, 16'h0001, 16'h8000); // 0x8000 minus 1
      issue(OPC_SUB, 16'h8000, 16'h0000);
      issue(OPC_SUB, 16'hffff, 16'h7fff);
      issue(OPC_ADD, 16'hffff, 16'h0001); // carry out only
      repeat (N_ARITH) begin
         a = rand_word();
         b = rand_word();
         if ($urandom_range(0, 9) == 0) begin
            a = corner_word();
            b = corner_word();
         end
         issue(opcode_t'(4'($urandom_range(0, 3))), a, b);
      end

      test_name = "shift_cmp";
      repeat (N_SHIFT) begin
         a = rand_word();
         b = rand_word();
         if ($urandom_range(0, 4) == 0) begin
            a = corner_word(); // equal boundary operands
            b = a;
         end
         issue(opcode_t'(4'($urandom_range(4, 9))), a, b);
      end

      test_name = "branch";
      repeat (N_BRANCH)
         issue(opcode_t'(4'($urandom_range(10, 13))), sign_class_word(), rand_word());
      test_name = "jump";
      repeat (N_JUMP)
         issue(opcode_t'(4'($urandom_range(14, 15))), sign_class_word(), rand_word());

      test_name = "stream";
      repeat (N_STREAM) begin
         issue(opcode_t'(4'($urandom_range(0, 15))), rand_word(), rand_word());
         idle($urandom_range(0, MAX_GAP));
      end
      idle(4);

      if (q_due.size() != 0)
         stop_on_error("accepted inputs still pending at the end of the run");
      else begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ns
`include "exec_settings.svh"

module alu
   import exec_pkg::*;
(
   input  word_t   in_a,
   input  word_t   in_b,
   input  logic    cin,
   input  logic    inv_a,
   input  logic    inv_b,
   input  alu_op_t op,
   output word_t   out,
   output logic    ofl,
   output logic    lt,
   output logic    lte
);

   localparam int W    = `EXEC_DATA_W;
   localparam int SH_W = $clog2(W);

   word_t           a;
   word_t           b;
   word_t           sum;
   word_t           diff;
   logic [SH_W-1:0] shamt;
   logic [2*W-1:0]  rol_ext;
   logic [2*W-1:0]  ror_ext;
   logic            diff_ofl;
   logic            eq;

   // operand conditioning ahead of every function
   assign a = inv_a ? ~in_a : in_a;
   assign b = inv_b ? ~in_b : in_b;

   assign shamt = b[SH_W-1:0]; // only low bits count

   // rotates via a doubled word
   assign rol_ext = {a, a} << shamt;
   assign ror_ext = {a, a} >> shamt;

   assign sum = a + b + word_t'(cin);

   // overflow when both adder inputs agree in sign but the sum does not
   assign ofl = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);

   // signed compare of the raw operands, independent of the invert controls
   assign diff     = in_a - in_b;
   assign diff_ofl = (in_a[W-1] != in_b[W-1]) && (diff[W-1] != in_a[W-1]);
   assign eq       = (in_a == in_b);
   assign lt       = diff[W-1] ^ diff_ofl; // sign fixed up on overflow
   assign lte      = lt | eq;

   always_comb begin
      case (op)
         ALU_ROL: out = rol_ext[2*W-1:W];
         ALU_SLL: out = a << shamt;
         ALU_ROR: out = ror_ext[W-1:0];
         ALU_SRL: out = a >> shamt;
         ALU_ADD: out = sum;
         ALU_AND: out = a & b;
         ALU_OR:  out = a | b;
         ALU_XOR: out = a ^ b;
         default: out = sum;
      endcase
   end

endmodule

// ==== verilog/ctrl_decode.sv ====
`timescale 1ns/1ns

module ctrl_decode
   import exec_pkg::*;
(
   input  opcode_t  opcode,
   output alu_op_t  alu_op,
   output logic     inv_a,
   output logic     inv_b,
   output logic     cin,
   output logic     sel_slt,
   output logic     sel_sle,
   output logic     br_instr,
   output logic     jmp_instr,
   output logic     jmp_reg,
   output logic     ofl_en,
   output br_cond_t br_cond
);

   always_comb begin
      // defaults give a plain add with no redirect
      alu_op    = ALU_ADD;
      inv_a     = 1'b0;
      inv_b     = 1'b0;
      cin       = 1'b0;
      sel_slt   = 1'b0;
      sel_sle   = 1'b0;
      br_instr  = 1'b0;
      jmp_instr = 1'b0;
      jmp_reg   = 1'b0;
      ofl_en    = 1'b0;
      br_cond   = BR_EQZ;

      case (opcode)
         OPC_ADD: ofl_en = 1'b1;
         OPC_SUB: begin
            // b - a as ~a + b + 1
            inv_a  = 1'b1;
            cin    = 1'b1;
            ofl_en = 1'b1;
         end
         OPC_XOR: alu_op = ALU_XOR;
         OPC_ANDN: begin
            alu_op = ALU_AND;
            inv_b  = 1'b1;
         end
         OPC_ROL: alu_op = ALU_ROL;
         OPC_SLL: alu_op = ALU_SLL;
         OPC_ROR: alu_op = ALU_ROR;
         OPC_SRL: alu_op = ALU_SRL;
         OPC_SLT: sel_slt = 1'b1; // flag replaces alu output
         OPC_SLE: sel_sle = 1'b1;
         OPC_BEQZ: begin
            br_instr = 1'b1;
            br_cond  = BR_EQZ;
         end
         OPC_BNEZ: begin
            br_instr = 1'b1;
            br_cond  = BR_NEZ;
         end
         OPC_BLTZ: begin
            br_instr = 1'b1;
            br_cond  = BR_LTZ;
         end
         OPC_BGEZ: begin
            br_instr = 1'b1;
            br_cond  = BR_GEZ;
         end
         OPC_J:  jmp_instr = 1'b1;
         OPC_JR: begin
            jmp_instr = 1'b1;
            jmp_reg   = 1'b1; // target from register
         end
         default: ;
      endcase
   end

endmodule

// ==== verilog/exec_pkg.sv ====
`include "exec_settings.svh"

package exec_pkg;

   typedef logic [`EXEC_DATA_W-1:0] word_t;

   // instruction kinds seen by the execute stage
   typedef enum logic [`EXEC_OP_W-1:0] {
      OPC_ADD, OPC_SUB, OPC_XOR, OPC_ANDN,
      OPC_ROL, OPC_SLL, OPC_ROR, OPC_SRL,
      OPC_SLT, OPC_SLE,
      OPC_BEQZ, OPC_BNEZ, OPC_BLTZ, OPC_BGEZ, // branch group
      OPC_J, OPC_JR                           // jump group
   } opcode_t;

   // alu function encoding, shifts in the low half
   typedef enum logic [2:0] {
      ALU_ROL = 3'b000,
      ALU_SLL = 3'b001,
      ALU_ROR = 3'b010,
      ALU_SRL = 3'b011,
      ALU_ADD = 3'b100,
      ALU_AND = 3'b101,
      ALU_OR  = 3'b110,
      ALU_XOR = 3'b111
   } alu_op_t;

   typedef enum logic [1:0] {BR_EQZ, BR_NEZ, BR_LTZ, BR_GEZ} br_cond_t;

endpackage

// ==== verilog/exec_top.sv ====
`timescale 1ns/1ns

module exec_top
   import exec_pkg::*;
(
   input  logic    clk,
   input  logic    arst_n,
   input  logic    in_valid,
   input  opcode_t opcode,
   input  word_t   oprnd_1,
   input  word_t   oprnd_2,
   input  word_t   pc_inc,
   output logic    out_valid,
   output logic    ofl,
   output logic    pc_src,
   output word_t   result,
   output word_t   pc_target
);

   // input stage
   logic    s1_valid;
   opcode_t s1_opcode;
   word_t   s1_oprnd_1;
   word_t   s1_oprnd_2;
   word_t   s1_pc_inc;

   // decoder to execute
   alu_op_t  alu_op;
   br_cond_t br_cond;
   logic     inv_a;
   logic     inv_b;
   logic     cin;
   logic     sel_slt;
   logic     sel_sle;
   logic     br_instr;
   logic     jmp_instr;
   logic     jmp_reg;
   logic     ofl_en;

   // execute results ahead of the output register
   word_t ex_result;
   word_t ex_pc_target;
   logic  ex_ofl;
   logic  ex_pc_src;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s1_valid   <= 1'b0;
         s1_opcode  <= OPC_ADD;
         s1_oprnd_1 <= '0;
         s1_oprnd_2 <= '0;
         s1_pc_inc  <= '0;
      end else begin
         s1_valid   <= in_valid; // no stall, sample every cycle
         s1_opcode  <= opcode;
         s1_oprnd_1 <= oprnd_1;
         s1_oprnd_2 <= oprnd_2;
         s1_pc_inc  <= pc_inc;
      end
   end

   ctrl_decode u_decode (
      .opcode    (s1_opcode),
      .alu_op    (alu_op),
      .inv_a     (inv_a),
      .inv_b     (inv_b),
      .cin       (cin),
      .sel_slt   (sel_slt),
      .sel_sle   (sel_sle),
      .br_instr  (br_instr),
      .jmp_instr (jmp_instr),
      .jmp_reg   (jmp_reg),
      .ofl_en    (ofl_en),
      .br_cond   (br_cond)
   );

   execute u_execute (
      .oprnd_1   (s1_oprnd_1),
      .oprnd_2   (s1_oprnd_2),
      .pc_inc    (s1_pc_inc),
      .alu_op    (alu_op),
      .inv_a     (inv_a),
      .inv_b     (inv_b),
      .cin       (cin),
      .sel_slt   (sel_slt),
      .sel_sle   (sel_sle),
      .br_cond   (br_cond),
      .br_instr  (br_instr),
      .jmp_instr (jmp_instr),
      .jmp_reg   (jmp_reg),
      .ofl_en    (ofl_en),
      .result    (ex_result),
      .pc_target (ex_pc_target),
      .ofl       (ex_ofl),
      .pc_src    (ex_pc_src)
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         out_valid <= 1'b0;
         ofl       <= 1'b0;
         pc_src    <= 1'b0;
         result    <= '0;
         pc_target <= '0;
      end else begin
         out_valid <= s1_valid;
         ofl       <= ex_ofl;
         pc_src    <= ex_pc_src & s1_valid; // bubbles never redirect
         result    <= ex_result;
         pc_target <= ex_pc_target;
      end
   end

endmodule

// ==== verilog/execute.sv ====
`timescale 1ns/1ns
`include "exec_settings.svh"

module execute
   import exec_pkg::*;
(
   input  word_t    oprnd_1,
   input  word_t    oprnd_2,
   input  word_t    pc_inc,
   input  alu_op_t  alu_op,
   input  logic     inv_a,
   input  logic     inv_b,
   input  logic     cin,
   input  logic     sel_slt,
   input  logic     sel_sle,
   input  br_cond_t br_cond,
   input  logic     br_instr,
   input  logic     jmp_instr,
   input  logic     jmp_reg,
   input  logic     ofl_en,
   output word_t    result,
   output word_t    pc_target,
   output logic     ofl,
   output logic     pc_src
);

   word_t alu_out;
   word_t pc_br;
   word_t pc_reg;
   logic  alu_ofl;
   logic  lt;
   logic  lte;
   logic  taken;

   alu u_alu (
      .in_a  (oprnd_1),
      .in_b  (oprnd_2),
      .cin   (cin),
      .inv_a (inv_a),
      .inv_b (inv_b),
      .op    (alu_op),
      .out   (alu_out),
      .ofl   (alu_ofl),
      .lt    (lt),
      .lte   (lte)
   );

   assign result = sel_slt ? word_t'(lt) : (sel_sle ? word_t'(lte) : alu_out);
   assign ofl    = alu_ofl & ofl_en; // only add/sub report overflow

   // branch condition on operand 1 against zero
   always_comb begin
      case (br_cond)
         BR_EQZ:  taken = ~|oprnd_1;
         BR_NEZ:  taken = |oprnd_1;
         BR_LTZ:  taken = oprnd_1[`EXEC_DATA_W-1];
         BR_GEZ:  taken = ~oprnd_1[`EXEC_DATA_W-1];
         default: taken = 1'b0;
      endcase
   end

   assign pc_src = jmp_instr | (br_instr & taken);

   assign pc_br     = pc_inc + (oprnd_2 << 1); // word offset
   assign pc_reg    = pc_inc + oprnd_1;
   assign pc_target = jmp_reg ? pc_reg : pc_br;

endmodule
